//--- Bender.yml
package:
  name: multiport_vdma_wr

sources:
  - vdma_pkg.sv
  - channel_line_buffer.sv
  - ddr_addr_counter.sv
  - ddr_write_fsm.sv
  - multiport_vdma_wr.sv
  - target: test
    files:
      - tb_ddr_app_model.sv
      - tb_multiport_vdma_wr.sv

//--- channel_line_buffer.sv
// --------------------------------------------------
// per-channel pixel packer and word FIFO
//   four pixels per DDR word, pixel 0 in low bits
//   circular buffer with fill count
//   registered burst-ready flag, sticky overflow
// --------------------------------------------------
`default_nettype none

module channel_line_buffer #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                axi_m00_inf,
    input  logic                rst,
    input  logic                enable,
    input  vdma_pkg::video_in_t vin,
    input  logic                pop,
    output vdma_pkg::ddr_word_t head,
    output logic                burst_ready,
    output logic                overflow
);
    import vdma_pkg::*;

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    // word storage, no reset needed
    ddr_word_t        mem [FIFO_DEPTH];
    ddr_word_t        pack_reg;
    ddr_word_t        pack_next;
    logic [1:0]       phase;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   fill;
    logic [PTR_W:0]   fill_next;
    logic             pix_take;
    logic             word_done;
    logic             fifo_full;
    logic             push;

    // --------------------------------------------------
    // packing
    // --------------------------------------------------
    // vsync wins over a pixel in the same cycle
    assign pix_take  = vin.de && enable && !vin.vsync;
    assign word_done = pix_take && (phase == 2'(PIX_PER_WORD - 1));

    // new pixel enters at the top, older ones slide down
    assign pack_next = {vin.data, pack_reg[DDR_DSIZE-1:PIX_W]};

    always_ff @(posedge axi_m00_inf) begin
        if (pix_take) begin
            pack_reg <= pack_next;
        end
    end

    // --------------------------------------------------
    // word FIFO
    // --------------------------------------------------
    assign fifo_full = (fill == (PTR_W + 1)'(FIFO_DEPTH));
    // completed word goes straight in, so it is visible next cycle
    assign push      = word_done && !fifo_full;
    assign head      = mem[rd_ptr];

    always_comb begin
        if (vin.vsync) begin
            fill_next = '0;
        end else begin
            fill_next = fill + (PTR_W + 1)'(push) - (PTR_W + 1)'(pop);
        end
    end

    always_ff @(posedge axi_m00_inf) begin
        if (push) begin
            mem[wr_ptr] <= pack_next;
        end
    end

    always_ff @(posedge axi_m00_inf) begin
        if (rst) begin
            phase       <= '0;
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            fill        <= '0;
            burst_ready <= 1'b0;
            overflow    <= 1'b0;
        end else begin
            fill        <= fill_next;
            burst_ready <= (fill_next >= (PTR_W + 1)'(BURST_LEN));
            // word lost on a full FIFO, flag held until reset
            if (word_done && fifo_full) begin
                overflow <= 1'b1;
            end
            if (vin.vsync) begin
                // frame restart, partial word and buffered words dropped
                // expected during blanking, after the last burst drained
                phase  <= '0;
                wr_ptr <= '0;
                rd_ptr <= '0;
            end else begin
                if (pix_take) begin
                    phase <= phase + 2'd1;
                end
                if (push) begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
                if (pop) begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
        end
    end

    // --------------------------------------------------
    // checks
    // --------------------------------------------------
    // sequencer only pops words that were announced as a burst
    a_pop_not_empty: assert property (@(posedge axi_m00_inf) disable iff (rst)
        pop |-> (fill != '0))
        else $error("pop seen while the channel FIFO is empty");

    a_fill_bound: assert property (@(posedge axi_m00_inf) disable iff (rst)
        fill <= (PTR_W + 1)'(FIFO_DEPTH))
        else $error("channel FIFO fill above its depth");

endmodule

`default_nettype wire

//--- ddr_addr_counter.sv
// --------------------------------------------------
// per-channel DDR word address counter
//   word index within the frame, base plus offset
//   wraps after one frame, one-cycle frame pulse
// --------------------------------------------------
`default_nettype none

module ddr_addr_counter #(
    parameter int FRAME_WORDS = 64
) (
    input  logic                axi_m00_inf,
    input  logic                rst,
    input  vdma_pkg::ddr_addr_t base,
    input  logic                restart,
    input  logic                advance,
    output vdma_pkg::ddr_addr_t addr,
    output logic                frame_done
);
    import vdma_pkg::*;

    localparam int IDX_W = $clog2(FRAME_WORDS);

    logic [IDX_W-1:0] idx;
    logic             wrap;

    // last word of the frame being consumed
    assign wrap = advance && (idx == IDX_W'(FRAME_WORDS - 1));

    // byte address of the current word
    assign addr = base + ddr_addr_t'(idx) * ddr_addr_t'(ADDR_STEP);

    always_ff @(posedge axi_m00_inf) begin
        if (rst) begin
            idx        <= '0;
            frame_done <= 1'b0;
        end else begin
            // no frame pulse when vsync cuts the frame short
            frame_done <= wrap && !restart;
            if (restart) begin
                idx <= '0;
            end else if (wrap) begin
                idx <= '0;
            end else if (advance) begin
                idx <= idx + 1'b1;
            end
        end
    end

    // --------------------------------------------------
    // checks
    // --------------------------------------------------
    a_idx_range: assert property (@(posedge axi_m00_inf) disable iff (rst)
        int'(idx) < FRAME_WORDS)
        else $error("frame word index out of range");

endmodule

`default_nettype wire

//--- ddr_write_fsm.sv
// --------------------------------------------------
// shared DDR write sequencer
//   round-robin grant over ready channels
//   fixed-length bursts on the native port
//   one data beat per write command
// --------------------------------------------------
`default_nettype none

module ddr_write_fsm #(
    parameter int NUM_CH = 2
) (
    input  logic                               axi_m00_inf,
    input  logic                               rst,
    input  logic                [NUM_CH-1:0]   burst_ready,
    input  vdma_pkg::ddr_word_t [NUM_CH-1:0]   head,
    input  vdma_pkg::ddr_addr_t [NUM_CH-1:0]   addr,
    input  vdma_pkg::app_stat_t                app_stat,
    output logic                [NUM_CH-1:0]   pop,
    output vdma_pkg::app_cmd_t                 app_cmd,
    output vdma_pkg::app_wdf_t                 app_wdf
);
    import vdma_pkg::*;

    localparam int CH_W   = (NUM_CH > 1) ? $clog2(NUM_CH) : 1;
    localparam int BEAT_W = $clog2(BURST_LEN);

    typedef enum logic [1:0] {
        IDLE,
        GRANT,
        WRITE
    } state_t;

    state_t            state;
    logic [CH_W-1:0]   grant;
    logic [CH_W-1:0]   last_ch;
    logic [CH_W-1:0]   next_ch;
    logic              next_found;
    logic [BEAT_W-1:0] beat_cnt;
    logic              beat_ok;
    logic              last_beat;

    // --------------------------------------------------
    // beat handshake
    // --------------------------------------------------
    // command and data both taken in the same cycle
    assign beat_ok   = (state == WRITE) && app_stat.rdy && app_stat.wdf_rdy;
    assign last_beat = beat_ok && (beat_cnt == BEAT_W'(BURST_LEN - 1));

    // granted channel drives the port
    always_comb begin
        app_cmd.addr     = addr[grant];
        app_cmd.cmd      = CMD_WRITE;
        app_cmd.en       = (state == WRITE);
        app_wdf.data     = head[grant];
        app_wdf.mask     = '0;
        app_wdf.data_end = 1'b1;
        app_wdf.wren     = (state == WRITE);
    end

    // pop the head word of the granted channel per accepted beat
    always_comb begin
        pop = '0;
        if (beat_ok) begin
            pop[grant] = 1'b1;
        end
    end

    // --------------------------------------------------
    // round-robin pick
    // --------------------------------------------------
    // search starts just after the last channel served
    always_comb begin
        next_ch    = last_ch;
        next_found = 1'b0;
        for (int i = 1; i <= NUM_CH; i++) begin
            if (!next_found && burst_ready[(int'(last_ch) + i) % NUM_CH]) begin
                next_ch    = CH_W'((int'(last_ch) + i) % NUM_CH);
                next_found = 1'b1;
            end
        end
    end

    // --------------------------------------------------
    // sequencer
    // --------------------------------------------------
    always_ff @(posedge axi_m00_inf) begin
        if (rst) begin
            state    <= IDLE;
            grant    <= '0;
            // channel 0 gets first turn
            last_ch  <= CH_W'(NUM_CH - 1);
            beat_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    // hold off until the controller is calibrated
                    if (app_stat.calib_done) begin
                        state <= GRANT;
                    end
                end
                GRANT: begin
                    if (!app_stat.calib_done) begin
                        state <= IDLE;
                    end else if (next_found) begin
                        grant    <= next_ch;
                        beat_cnt <= '0;
                        state    <= WRITE;
                    end
                end
                WRITE: begin
                    if (beat_ok) begin
                        beat_cnt <= beat_cnt + 1'b1;
                    end
                    // burst ends on its last accepted beat
                    if (last_beat) begin
                        last_ch <= grant;
                        state   <= GRANT;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // --------------------------------------------------
    // checks
    // --------------------------------------------------
    // stalled command keeps address and data from the channel
    a_hold_stalled: assert property (@(posedge axi_m00_inf) disable iff (rst)
        (app_cmd.en && !(app_stat.rdy && app_stat.wdf_rdy)) |=>
        (app_cmd.en && $stable(app_cmd.addr) && $stable(app_wdf.data)))
        else $error("write command changed while stalled");

    // both enables stay up together until the beat is taken
    a_en_wren: assert property (@(posedge axi_m00_inf) disable iff (rst)
        (app_wdf.wren && !(app_stat.rdy && app_stat.wdf_rdy)) |=>
        (app_cmd.en && app_wdf.wren))
        else $error("command enable and write data enable dropped while stalled");

    a_one_pop: assert property (@(posedge axi_m00_inf) disable iff (rst)
        $onehot0(pop))
        else $error("more than one channel popped in a cycle");

endmodule

`default_nettype wire

//--- filelist.f
vdma_pkg.sv
channel_line_buffer.sv
ddr_addr_counter.sv
ddr_write_fsm.sv
multiport_vdma_wr.sv
tb_ddr_app_model.sv
tb_multiport_vdma_wr.sv

//--- multiport_vdma_wr.sv
// --------------------------------------------------
// multi-channel video frame writer, top level
//   per channel: pixel packer FIFO, address counter
//   one shared write sequencer on the DDR port
// --------------------------------------------------
`default_nettype none

module multiport_vdma_wr #(
    parameter int NUM_CH      = 2,
    parameter int FRAME_WORDS = 64,
    parameter int FIFO_DEPTH  = 16
) (
    input  logic                               axi_m00_inf,
    input  logic                               rst,
    // channel side
    input  logic                [NUM_CH-1:0]   ch_enable,
    input  vdma_pkg::ddr_addr_t [NUM_CH-1:0]   wr_baseaddr,
    input  vdma_pkg::video_in_t [NUM_CH-1:0]   vin,
    output logic                [NUM_CH-1:0]   overflow,
    // DDR native port
    input  vdma_pkg::app_stat_t                app_stat,
    output vdma_pkg::app_cmd_t                 app_cmd,
    output vdma_pkg::app_wdf_t                 app_wdf
);
    import vdma_pkg::*;

    // channel to sequencer
    logic      [NUM_CH-1:0] burst_ready;
    ddr_word_t [NUM_CH-1:0] head;
    ddr_addr_t [NUM_CH-1:0] ch_addr;
    // sequencer to channel
    logic      [NUM_CH-1:0] pop;

    // --------------------------------------------------
    // per-channel write path
    // --------------------------------------------------
    for (genvar c = 0; c < NUM_CH; c++) begin : g_ch

        channel_line_buffer #(
            .FIFO_DEPTH (FIFO_DEPTH)
        ) u_line_buffer (
            .axi_m00_inf (axi_m00_inf),
            .rst         (rst),
            .enable      (ch_enable[c]),
            .vin         (vin[c]),
            .pop         (pop[c]),
            .head        (head[c]),
            .burst_ready (burst_ready[c]),
            .overflow    (overflow[c])
        );

        // address steps with each word the sequencer takes
        // vsync restarts the frame at the base
        ddr_addr_counter #(
            .FRAME_WORDS (FRAME_WORDS)
        ) u_addr_counter (
            .axi_m00_inf (axi_m00_inf),
            .rst         (rst),
            .base        (wr_baseaddr[c]),
            .restart     (vin[c].vsync),
            .advance     (pop[c]),
            .addr        (ch_addr[c]),
            .frame_done  ()
        );

    end

    // --------------------------------------------------
    // shared sequencer
    // --------------------------------------------------
    ddr_write_fsm #(
        .NUM_CH (NUM_CH)
    ) u_write_fsm (
        .axi_m00_inf (axi_m00_inf),
        .rst         (rst),
        .burst_ready (burst_ready),
        .head        (head),
        .addr        (ch_addr),
        .app_stat    (app_stat),
        .pop         (pop),
        .app_cmd     (app_cmd),
        .app_wdf     (app_wdf)
    );

endmodule

`default_nettype wire

//--- tb_ddr_app_model.sv
// --------------------------------------------------
// testbench model of the DDR native write port
//   calibration and stall controls from the testbench
//   random low periods on rdy and wdf_rdy
//   accepted beat strobe and write log count
// --------------------------------------------------
`default_nettype none

module tb_ddr_app_model (
    input  logic                axi_m00_inf,
    input  logic                rst,
    input  logic                calib,
    input  logic                hold,
    input  vdma_pkg::app_cmd_t  app_cmd,
    input  vdma_pkg::app_wdf_t  app_wdf,
    output vdma_pkg::app_stat_t app_stat,
    output logic                beat,
    output int                  beat_count,
    output int                  bad_cmds
);
    timeunit 1ns;
    timeprecision 1ps;
    import vdma_pkg::*;

    int   seed;
    int   rdy_low;
    int   wdf_low;
    logic rdy_q;
    logic wdf_q;

    initial begin
        seed     = 13089;
        bad_cmds = 0;
    end

    // hold keeps the command side stalled
    assign rdy_q    = !hold && (rdy_low == 0);
    assign wdf_q    = (wdf_low == 0);
    assign app_stat = {rdy_q, wdf_q, calib};
    assign beat     = app_cmd.en && app_wdf.wren && rdy_q && wdf_q;

    // --------------------------------------------------
    // stall generator and write log
    // --------------------------------------------------
    // one in four chance per cycle of a low stretch, 1 to 4 cycles
    always @(posedge axi_m00_inf) begin
        if (rst) begin
            rdy_low    <= 0;
            wdf_low    <= 0;
            beat_count <= 0;
        end else begin
            if (rdy_low != 0) begin
                rdy_low <= rdy_low - 1;
            end else if (($random(seed) & 3) == 0) begin
                rdy_low <= 1 + ($random(seed) & 3);
            end
            if (wdf_low != 0) begin
                wdf_low <= wdf_low - 1;
            end else if (($random(seed) & 3) == 0) begin
                wdf_low <= 1 + ($random(seed) & 3);
            end
            if (beat) begin
                beat_count <= beat_count + 1;
            end
        end
    end

    // write-only port
    a_no_read: assert property (@(posedge axi_m00_inf) disable iff (rst)
        app_cmd.en |-> (app_cmd.cmd != CMD_READ))
        else begin
            bad_cmds++;
            $display("error at %0t: read command issued on the write port", $time);
        end

endmodule

`default_nettype wire

//--- tb_multiport_vdma_wr.sv
// --------------------------------------------------
// testbench for the multi-channel video frame writer
//   clock, reset and pixel stimulus on two channels
//   scoreboard of expected words and addresses
//   checking assertions and the closing report
// --------------------------------------------------
`default_nettype none

module tb_multiport_vdma_wr;
    timeunit 1ns;
    timeprecision 1ps;
    import vdma_pkg::*;

    localparam int NUM_CH      = 2;
    localparam int FRAME_WORDS = 64;
    localparam int FIFO_DEPTH  = 16;

    logic                   axi_m00_inf;
    logic                   rst;
    logic      [NUM_CH-1:0] ch_enable;
    ddr_addr_t [NUM_CH-1:0] wr_baseaddr;
    video_in_t [NUM_CH-1:0] vin;
    logic      [NUM_CH-1:0] overflow;
    app_stat_t              app_stat;
    app_cmd_t               app_cmd;
    app_wdf_t               app_wdf;
    logic                   calib;
    logic                   hold;
    logic                   beat;
    int                     beat_count;
    int                     bad_cmds;
    // scoreboard, one queue of expected words per channel
    ddr_word_t              exp_q [NUM_CH][$];
    ddr_word_t              pack [NUM_CH];
    int                     pix_cnt [NUM_CH];
    int                     exp_idx [NUM_CH];
    int                     seed;
    int                     err_value;
    int                     err_other;
    // expectations for the current cycle, settled on the falling edge
    int                     beat_ch;
    int                     exp_ch;
    logic                   have_word;
    ddr_word_t              exp_word;
    ddr_addr_t              exp_addr;
    // burst run tracking
    int                     run_len;
    int                     run_ch;
    int                     last_burst_ch;
    logic                   alt_req;
    // port state one cycle back
    logic                   prev_stall;
    ddr_addr_t              prev_addr;
    ddr_word_t              prev_data;
    logic                   prev_ovf;
    logic                   ovf_expect;

    multiport_vdma_wr #(
        .NUM_CH      (NUM_CH),
        .FRAME_WORDS (FRAME_WORDS),
        .FIFO_DEPTH  (FIFO_DEPTH)
    ) DUT (
        .axi_m00_inf (axi_m00_inf),
        .rst         (rst),
        .ch_enable   (ch_enable),
        .wr_baseaddr (wr_baseaddr),
        .vin         (vin),
        .overflow    (overflow),
        .app_stat    (app_stat),
        .app_cmd     (app_cmd),
        .app_wdf     (app_wdf)
    );

    tb_ddr_app_model u_ddr_model (
        .axi_m00_inf (axi_m00_inf),
        .rst         (rst),
        .calib       (calib),
        .hold        (hold),
        .app_cmd     (app_cmd),
        .app_wdf     (app_wdf),
        .app_stat    (app_stat),
        .beat        (beat),
        .beat_count  (beat_count),
        .bad_cmds    (bad_cmds)
    );

    initial begin
        axi_m00_inf = 1'b0;
        forever #50 axi_m00_inf = ~axi_m00_inf;
    end

    // --------------------------------------------------
    // helpers
    // --------------------------------------------------
    task automatic count_mismatch(input string name, input logic [63:0] exp_v,
                                  input logic [63:0] act_v);
        err_value++;
        $display("mismatch at %0t: %s expected %h got %h", $time, name, exp_v, act_v);
    endtask

    task automatic log_failure(input string what);
        err_other++;
        $display("error at %0t: %s", $time, what);
    endtask

    // channel whose frame window holds the address, NUM_CH if none
    function automatic int chan_of(input ddr_addr_t a);
        int c;
        chan_of = NUM_CH;
        for (c = 0; c < NUM_CH; c++) begin
            if (a >= wr_baseaddr[c] && a < wr_baseaddr[c] + FRAME_WORDS * ADDR_STEP) begin
                chan_of = c;
            end
        end
    endfunction

    // pixel k of a word lands at bits 16k up, word dropped when FIFO is full
    task automatic record_pixel(input int c, input pixel_t pix);
        pack[c][pix_cnt[c]*PIX_W +: PIX_W] = pix;
        pix_cnt[c]++;
        if (pix_cnt[c] == PIX_PER_WORD) begin
            if (exp_q[c].size() < FIFO_DEPTH) begin
                exp_q[c].push_back(pack[c]);
            end
            pix_cnt[c] = 0;
        end
    endtask

    // one pixel every other cycle on every channel
    task automatic send_pixels(input int n);
        pixel_t pix;
        for (int i = 0; i < 2 * n; i++) begin
            @(posedge axi_m00_inf);
            for (int c = 0; c < NUM_CH; c++) begin
                pix = pixel_t'($random(seed));
                vin[c].de   <= (i % 2 == 0);
                vin[c].data <= pix;
                if (i % 2 == 0 && ch_enable[c]) begin
                    record_pixel(c, pix);
                end
            end
        end
    endtask

    // vsync strobe, frame count and pending words start over
    task automatic restart_channel(input int c);
        @(posedge axi_m00_inf);
        vin[c].vsync <= 1'b1;
        exp_q[c].delete();
        pix_cnt[c] = 0;
        exp_idx[c] = 0;
        @(posedge axi_m00_inf);
        vin[c].vsync <= 1'b0;
    endtask

    // until no full burst is left and the port is idle
    task automatic wait_drain(input int limit);
        int n;
        n = 0;
        while (exp_q[0].size() >= BURST_LEN || exp_q[1].size() >= BURST_LEN ||
               run_len != 0 || app_cmd.en) begin
            @(negedge axi_m00_inf);
            n++;
            if (n > limit) begin
                $display("timeout: bursts still pending after %0d cycles", limit);
                $display("SOME TESTS FAILED");
                $finish;
            end
        end
    endtask

    // --------------------------------------------------
    // scoreboard
    // --------------------------------------------------
    always @(negedge axi_m00_inf) begin
        beat_ch   = chan_of(app_cmd.addr);
        have_word = 1'b0;
        exp_word  = '0;
        exp_addr  = '0;
        if (beat_ch < NUM_CH && exp_q[beat_ch].size() != 0) begin
            have_word = 1'b1;
            exp_word  = exp_q[beat_ch][0];
            exp_addr  = wr_baseaddr[beat_ch] +
                        ddr_addr_t'((exp_idx[beat_ch] % FRAME_WORDS) * ADDR_STEP);
        end
        // mid-burst stays on one channel, a waiting peer takes the next burst
        exp_ch = (run_len != 0) ? run_ch : (alt_req ? 1 - last_burst_ch : beat_ch);
    end

    always @(posedge axi_m00_inf) begin
        prev_stall <= app_cmd.en && !(app_stat.rdy && app_stat.wdf_rdy);
        prev_addr  <= app_cmd.addr;
        prev_data  <= app_wdf.data;
        prev_ovf   <= overflow[0];
        if (!rst && beat && have_word) begin
            void'(exp_q[beat_ch].pop_front());
            exp_idx[beat_ch]++;
            if (run_len == 0) begin
                run_ch  = beat_ch;
                alt_req = 1'b0;
            end
            run_len++;
            if (run_len == BURST_LEN) begin
                run_len       = 0;
                last_burst_ch = beat_ch;
                // margin of one word for the packer-to-FIFO delay
                alt_req       = (exp_q[1 - beat_ch].size() > BURST_LEN);
            end
        end
    end

    // --------------------------------------------------
    // checks
    // --------------------------------------------------
    a_uncalibrated: assert property (@(posedge axi_m00_inf) disable iff (rst)
        !app_stat.calib_done |-> (!app_cmd.en && !app_wdf.wren))
        else log_failure("write issued before calibration completed");
    a_pending: assert property (@(posedge axi_m00_inf) disable iff (rst)
        beat |-> have_word)
        else log_failure("write beat with no pending word for its address");
    a_data: assert property (@(posedge axi_m00_inf) disable iff (rst)
        (beat && have_word) |-> (app_wdf.data == exp_word))
        else count_mismatch("app_wdf.data", exp_word, $sampled(app_wdf.data));
    a_addr: assert property (@(posedge axi_m00_inf) disable iff (rst)
        (beat && have_word) |-> (app_cmd.addr == exp_addr))
        else count_mismatch("app_cmd.addr", exp_addr, $sampled(app_cmd.addr));
    a_fields: assert property (@(posedge axi_m00_inf) disable iff (rst)
        beat |-> ({app_cmd.cmd, app_wdf.mask, app_wdf.data_end} == {CMD_WRITE, 8'h00, 1'b1}))
        else count_mismatch("cmd/mask/data_end", {CMD_WRITE, 8'h00, 1'b1},
                            $sampled({app_cmd.cmd, app_wdf.mask, app_wdf.data_end}));
    a_burst_ch: assert property (@(posedge axi_m00_inf) disable iff (rst)
        (beat && have_word) |-> (beat_ch == exp_ch))
        else count_mismatch("burst channel", exp_ch, beat_ch);
    // stalled beat holds
    a_hold_addr: assert property (@(posedge axi_m00_inf) disable iff (rst)
        prev_stall |-> (app_cmd.en && app_cmd.addr == prev_addr))
        else count_mismatch("app_cmd.addr", $sampled(prev_addr), $sampled(app_cmd.addr));
    a_hold_data: assert property (@(posedge axi_m00_inf) disable iff (rst)
        prev_stall |-> (app_wdf.data == prev_data))
        else count_mismatch("app_wdf.data", $sampled(prev_data), $sampled(app_wdf.data));
    a_ovf_sticky: assert property (@(posedge axi_m00_inf) disable iff (rst)
        prev_ovf |-> overflow[0])
        else log_failure("overflow of channel 0 cleared without reset");
    a_ovf_other: assert property (@(posedge axi_m00_inf) disable iff (rst)
        !overflow[1])
        else log_failure("overflow raised on channel 1");
    a_ovf_raised: assert property (@(posedge axi_m00_inf) disable iff (rst)
        ovf_expect |-> overflow[0])
        else count_mismatch("overflow[0]", 64'd1, $sampled(overflow[0]));

    // --------------------------------------------------
    // stimulus
    // --------------------------------------------------
    initial begin
        seed           = 13089;
        err_value      = 0;
        err_other      = 0;
        rst            = 1'b1;
        ch_enable      = '1;
        wr_baseaddr[0] = 27'h010_0000;
        wr_baseaddr[1] = 27'h020_0000;
        vin            = '0;
        calib          = 1'b0;
        hold           = 1'b0;
        ovf_expect     = 1'b0;
        run_len        = 0;
        run_ch         = 0;
        last_burst_ch  = 0;
        alt_req        = 1'b0;
        for (int c = 0; c < NUM_CH; c++) begin
            pack[c]    = '0;
            pix_cnt[c] = 0;
            exp_idx[c] = 0;
        end
        repeat (3) @(posedge axi_m00_inf);
        rst <= 1'b0;
        // bursts pending while calibration is still running
        send_pixels(12 * PIX_PER_WORD);
        repeat (20) @(posedge axi_m00_inf);
        calib <= 1'b1;
        // more than one frame per channel, address wraps
        send_pixels(60 * PIX_PER_WORD);
        wait_drain(2000);
        restart_channel(0);
        restart_channel(1);
        send_pixels(10 * PIX_PER_WORD);
        wait_drain(1000);
        // channel 1 off, port stalled until channel 0 overruns
        @(posedge axi_m00_inf);
        ch_enable[1] <= 1'b0;
        hold         <= 1'b1;
        restart_channel(0);
        send_pixels(20 * PIX_PER_WORD);
        repeat (4) @(posedge axi_m00_inf);
        ovf_expect <= 1'b1;
        hold       <= 1'b0;
        wait_drain(1000);
        repeat (10) @(posedge axi_m00_inf);
        $display("errors: %0d mismatches, %0d other failures, %0d bad commands, %0d beats",
                 err_value, err_other, bad_cmds, beat_count);
        if (err_value == 0 && err_other == 0 && bad_cmds == 0 && beat_count > 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vdma_pkg.sv
// --------------------------------------------------
// shared definitions for the video frame writer
//   data and address widths, burst constants
//   native DDR command codes
//   packed structs for pixel input and DDR port
// --------------------------------------------------
`default_nettype none

package vdma_pkg;

    // --------------------------------------------------
    // widths
    // --------------------------------------------------
    localparam int PIX_W        = 16;
    localparam int DDR_DSIZE    = 64;
    localparam int PIX_PER_WORD = DDR_DSIZE / PIX_W;
    localparam int ASIZE        = 27;

    // burst shape on the native port
    localparam int BURST_LEN = 8;
    // byte address step for one DDR word
    localparam int ADDR_STEP = DDR_DSIZE / 8;

    // native port command codes
    localparam logic [2:0] CMD_WRITE = 3'd0;
    localparam logic [2:0] CMD_READ  = 3'd1;

    // --------------------------------------------------
    // basic types
    // --------------------------------------------------
    typedef logic [PIX_W-1:0]     pixel_t;
    typedef logic [DDR_DSIZE-1:0] ddr_word_t;
    typedef logic [ASIZE-1:0]     ddr_addr_t;

    // one pixel input, 18 bits
    typedef struct packed {
        logic   vsync;
        logic   de;
        pixel_t data;
    } video_in_t;

    // command channel towards the controller
    typedef struct packed {
        ddr_addr_t  addr;
        logic [2:0] cmd;
        logic       en;
    } app_cmd_t;

    // write data channel towards the controller
    typedef struct packed {
        ddr_word_t              data;
        logic [DDR_DSIZE/8-1:0] mask;
        logic                   data_end;
        logic                   wren;
    } app_wdf_t;

    // status back from the controller
    typedef struct packed {
        logic rdy;
        logic wdf_rdy;
        logic calib_done;
    } app_stat_t;

endpackage

`default_nettype wire
